// ==== Bender.yml ====
package:
  name: ir_txrx

sources:
  - files:
      - rtl/irPkg.sv
      - rtl/irCodeMem.sv
      - rtl/irRegIf.sv
      - rtl/irTx.sv
      - rtl/irRx.sv
      - rtl/irTxRxTop.sv
  - target: simulation
    files:
      - testbench/irTxRxTb.sv

// ==== rtl/irCodeMem.sv ====
// Two-bank code RAM with registered read data
`timescale 1ns/10ps
module irCodeMem #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic               CLK_i,
	input  logic               wRST,
	input  irPkg::irMemReq_t   memReq_i,
	output logic [7:0]         memRd_o
);

localparam int BANK_DEPTH = 2 ** (MEM_ADR_WIDTH - 1);

logic [7:0]                bankMem [2][BANK_DEPTH];
logic [7:0]                bankRd [2];
logic [MEM_ADR_WIDTH-2:0]  bankAdr;
logic                      topBit, rdSel;

assign bankAdr = memReq_i.adr[MEM_ADR_WIDTH-2:0];
assign topBit  = memReq_i.adr[MEM_ADR_WIDTH-1];  // Bank select

// Both banks read every request, bank picked afterwards
always_ff @(posedge CLK_i) begin
	for (int b = 0; b < 2; b++) begin
		if (memReq_i.we && (topBit == 1'(b))) bankMem[b][bankAdr] <= memReq_i.wd;
		if (memReq_i.re) bankRd[b] <= bankMem[b][bankAdr];
	end
end

// ********************
// Output register
// ********************
always_ff @(posedge CLK_i or posedge wRST) begin
	if (wRST) begin
		rdSel   <= 1'b0;
		memRd_o <= 8'd0;
	end else begin
		if (memReq_i.re) rdSel <= topBit;
		memRd_o <= rdSel ? bankRd[1] : bankRd[0];
	end
end

endmodule

// ==== rtl/irPkg.sv ====
// IR remote transmitter/receiver register map, FSM states and shared structs
package irPkg;

	typedef enum logic {
		IR_TX = 1'b0,
		IR_RX = 1'b1
	} irMode_e;

	// ********************
	// Register map
	// ********************
	typedef enum logic [7:0] {
		CTRL    = 8'h00,
		STATUS  = 8'h01,
		CRR_LO  = 8'h02,
		CRR_HI  = 8'h03,
		DUTY_LO = 8'h04,
		DUTY_HI = 8'h05,
		RPT     = 8'h06,
		OFF_TMO = 8'h07,
		BGN_LO  = 8'h08,
		BGN_HI  = 8'h09,
		END_LO  = 8'h0A,
		END_HI  = 8'h0B,
		LIM_LO  = 8'h0C,
		LIM_HI  = 8'h0D,
		REND_LO = 8'h0E,
		REND_HI = 8'h0F,
		MADR_LO = 8'h10,
		MADR_HI = 8'h11,
		MDATA   = 8'h12
	} irRegAdr_e;

	localparam int CTRL_START    = 0;
	localparam int CTRL_MODE     = 1;
	localparam int CTRL_INT_EN   = 2;
	localparam int CTRL_POL_INV  = 3;
	localparam int CTRL_GPIO_EN  = 4;
	localparam int CTRL_STOP     = 5;
	localparam int CTRL_SW_RST   = 6;
	localparam int STAT_BUSY     = 0;
	localparam int STAT_INT      = 1;

	typedef enum logic [2:0] {TX_IDLE, TX_FETCH, TX_MARK, TX_SPACE, TX_DONE} irTxState_e;
	typedef enum logic [2:0] {RX_IDLE, RX_WAIT, RX_RUN, RX_STORE, RX_DONE} irRxState_e;

	typedef struct packed {
		irMode_e     mode;
		logic [15:0] crrCycLen;   // Carrier period in clocks
		logic [15:0] txDutyLen;   // Carrier high time
		logic [7:0]  txRptLen;
		logic [7:0]  rxOffTmo;    // Silence timeout in units
		logic        rxPolInv;
		logic        rxGpioEn;
		logic [15:0] codeBgnAdr;
		logic [15:0] codeEndAdr;  // Exclusive
		logic [15:0] rxLimitAdr;  // Exclusive
	} irCfg_t;

	typedef struct packed {
		logic        we;
		logic        re;
		logic [15:0] adr;
		logic [7:0]  wd;
	} irMemReq_t;

endpackage

// ==== rtl/irRegIf.sv ====
// Wishbone register block with control, status, memory window and interrupt flag
`timescale 1ns/10ps
module irRegIf #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic               CLK_i,
	input  logic               RST_i,
	input  logic               wRST,
	input  logic [7:0]         wbAdr_i,
	input  logic [7:0]         wbDat_i,
	input  logic               wbWe_i,
	input  logic               wbStb_i,
	input  logic               wbCyc_i,
	input  logic               busy_i,
	input  logic               done_i,
	input  logic               startClr_i,
	input  logic               stopClr_i,
	input  logic [15:0]        rxCodeEndAdr_i,
	input  logic [7:0]         memRd_i,
	output logic [7:0]         wbDat_o,
	output logic               wbAck_o,
	output irPkg::irCfg_t      cfg_o,
	output logic               start_o,
	output logic               stop_o,
	output logic               swRst_o,
	output logic               int_o,
	output irPkg::irMemReq_t   memReq_o
);

localparam logic [15:0] ADR_MASK = 16'((32'd1 << MEM_ADR_WIDTH) - 32'd1);

irPkg::irCfg_t     cfgR;
irPkg::irRegAdr_e  regAdr;
logic              startR, stopR, intEn, intR, swRstArm;
logic [15:0]       memAdr, rendR;
logic [1:0]        rdCnt;      // Memory window read sequencer
logic              acc, memWin;
logic [7:0]        rdVal;

assign regAdr = irPkg::irRegAdr_e'(wbAdr_i);
assign acc    = wbStb_i & wbCyc_i & ~wbAck_o & (rdCnt == 2'd0);  // New access only
assign memWin = acc & (regAdr == irPkg::MDATA);

assign cfg_o   = cfgR;
assign start_o = startR;
assign stop_o  = stopR;
assign int_o   = intR;

// Host request goes straight to RAM so data lands in time for the third cycle
always_comb begin
	memReq_o.we  = memWin & wbWe_i;
	memReq_o.re  = memWin & ~wbWe_i;
	memReq_o.adr = memAdr;
	memReq_o.wd  = wbDat_i;
end

// ********************
// Read mux
// ********************
always_comb begin
	rdVal = 8'd0;
	case (regAdr)
		irPkg::CTRL: begin
			rdVal[irPkg::CTRL_START]   = startR;
			rdVal[irPkg::CTRL_MODE]    = cfgR.mode;
			rdVal[irPkg::CTRL_INT_EN]  = intEn;
			rdVal[irPkg::CTRL_POL_INV] = cfgR.rxPolInv;
			rdVal[irPkg::CTRL_GPIO_EN] = cfgR.rxGpioEn;
			rdVal[irPkg::CTRL_STOP]    = stopR;
		end
		irPkg::STATUS: begin
			rdVal[irPkg::STAT_BUSY] = busy_i;
			rdVal[irPkg::STAT_INT]  = intR;
		end
		irPkg::CRR_LO:  rdVal = cfgR.crrCycLen[7:0];
		irPkg::CRR_HI:  rdVal = cfgR.crrCycLen[15:8];
		irPkg::DUTY_LO: rdVal = cfgR.txDutyLen[7:0];
		irPkg::DUTY_HI: rdVal = cfgR.txDutyLen[15:8];
		irPkg::RPT:     rdVal = cfgR.txRptLen;
		irPkg::OFF_TMO: rdVal = cfgR.rxOffTmo;
		irPkg::BGN_LO:  rdVal = cfgR.codeBgnAdr[7:0];
		irPkg::BGN_HI:  rdVal = cfgR.codeBgnAdr[15:8];
		irPkg::END_LO:  rdVal = cfgR.codeEndAdr[7:0];
		irPkg::END_HI:  rdVal = cfgR.codeEndAdr[15:8];
		irPkg::LIM_LO:  rdVal = cfgR.rxLimitAdr[7:0];
		irPkg::LIM_HI:  rdVal = cfgR.rxLimitAdr[15:8];
		irPkg::REND_LO: rdVal = rendR[7:0];
		irPkg::REND_HI: rdVal = rendR[15:8];
		irPkg::MADR_LO: rdVal = memAdr[7:0];
		irPkg::MADR_HI: rdVal = memAdr[15:8];
		default:        rdVal = 8'd0;
	endcase
end

always_ff @(posedge CLK_i or posedge wRST) begin
	if (wRST) begin
		cfgR    <= '0;
		startR  <= 1'b0;
		stopR   <= 1'b0;
		intEn   <= 1'b0;
		intR    <= 1'b0;
		memAdr  <= 16'd0;
		rendR   <= 16'd0;
		rdCnt   <= 2'd0;
		wbAck_o <= 1'b0;
		wbDat_o <= 8'd0;
	end else begin
		wbAck_o <= 1'b0;
		rendR   <= rxCodeEndAdr_i;
		if (startClr_i) startR <= 1'b0;
		if (stopClr_i)  stopR  <= 1'b0;
		if (rdCnt == 2'd2) begin  // RAM data registered, finish window read
			wbDat_o <= memRd_i;
			wbAck_o <= 1'b1;
			rdCnt   <= 2'd0;
			memAdr  <= (memAdr + 16'd1) & ADR_MASK;
		end else if (rdCnt != 2'd0) begin
			rdCnt <= rdCnt + 2'd1;
		end
		if (memWin && !wbWe_i) begin
			rdCnt <= 2'd1;
		end else if (acc) begin
			wbAck_o <= 1'b1;
			wbDat_o <= rdVal;
		end
		if (acc && wbWe_i) begin
			case (regAdr)
				irPkg::CTRL: begin
					if (wbDat_i[irPkg::CTRL_START]) startR <= 1'b1;
					if (wbDat_i[irPkg::CTRL_STOP])  stopR  <= 1'b1;
					cfgR.mode     <= irPkg::irMode_e'(wbDat_i[irPkg::CTRL_MODE]);
					intEn         <= wbDat_i[irPkg::CTRL_INT_EN];
					cfgR.rxPolInv <= wbDat_i[irPkg::CTRL_POL_INV];
					cfgR.rxGpioEn <= wbDat_i[irPkg::CTRL_GPIO_EN];
				end
				irPkg::STATUS:  if (wbDat_i[irPkg::STAT_INT]) intR <= 1'b0;  // W1C
				irPkg::CRR_LO:  cfgR.crrCycLen[7:0]   <= wbDat_i;
				irPkg::CRR_HI:  cfgR.crrCycLen[15:8]  <= wbDat_i;
				irPkg::DUTY_LO: cfgR.txDutyLen[7:0]   <= wbDat_i;
				irPkg::DUTY_HI: cfgR.txDutyLen[15:8]  <= wbDat_i;
				irPkg::RPT:     cfgR.txRptLen         <= wbDat_i;
				irPkg::OFF_TMO: cfgR.rxOffTmo         <= wbDat_i;
				irPkg::BGN_LO:  cfgR.codeBgnAdr[7:0]  <= wbDat_i;
				irPkg::BGN_HI:  cfgR.codeBgnAdr[15:8] <= wbDat_i;
				irPkg::END_LO:  cfgR.codeEndAdr[7:0]  <= wbDat_i;
				irPkg::END_HI:  cfgR.codeEndAdr[15:8] <= wbDat_i;
				irPkg::LIM_LO:  cfgR.rxLimitAdr[7:0]  <= wbDat_i;
				irPkg::LIM_HI:  cfgR.rxLimitAdr[15:8] <= wbDat_i;
				irPkg::MADR_LO: memAdr[7:0]           <= wbDat_i;
				irPkg::MADR_HI: memAdr[15:8]          <= wbDat_i;
				irPkg::MDATA:   memAdr <= (memAdr + 16'd1) & ADR_MASK;
				default: ;
			endcase
		end
		if (done_i && intEn) intR <= 1'b1;  // Set wins over clear
	end
end

// Soft reset fires the cycle after its ack so the host still sees the ack
always_ff @(posedge CLK_i or posedge RST_i) begin
	if (RST_i) begin
		swRstArm <= 1'b0;
		swRst_o  <= 1'b0;
	end else begin
		swRstArm <= acc & wbWe_i & (regAdr == irPkg::CTRL) & wbDat_i[irPkg::CTRL_SW_RST];
		swRst_o  <= swRstArm;
	end
end

endmodule

// ==== rtl/irRx.sv ====
// IR receive engine, measures RXD runs in carrier periods and stores them
`timescale 1ns/10ps
module irRx #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic               CLK_i,
	input  logic               wRST,
	input  irPkg::irCfg_t      cfg_i,
	input  logic               start_i,
	input  logic               stop_i,
	input  logic               rxd_i,
	output irPkg::irMemReq_t   memReq_o,
	output logic               busy_o,
	output logic               done_o,
	output logic               startClr_o,
	output logic               stopClr_o,
	output logic [15:0]        rxCodeEndAdr_o,
	output logic               rxGpio_o
);

irPkg::irRxState_e         state;
logic                      rxS1, rxS2;     // Synchronizer, polarity corrected
logic                      curLvl;
logic [MEM_ADR_WIDTH-1:0]  adr, adrNext;
logic [15:0]               clkCnt, baseClk, nClk;
logic [7:0]                unitCnt, baseUnit, nUnit, storeVal;
logic                      rxOn, lvlChg, runStart, tmo;

assign rxOn     = (cfg_i.mode == irPkg::IR_RX);
assign rxGpio_o = rxS2 & cfg_i.rxGpioEn;
assign adrNext  = adr + 1'b1;
assign lvlChg   = (state == irPkg::RX_RUN) && (rxS2 != curLvl);
assign runStart = (state == irPkg::RX_WAIT) || lvlChg;

// ********************
// Unit counter
// ********************
always_comb begin
	baseClk  = runStart ? 16'd0 : clkCnt;
	baseUnit = runStart ? 8'd0 : unitCnt;
	nClk     = baseClk + 16'd1;
	nUnit    = baseUnit;
	if (nClk >= cfg_i.crrCycLen) begin
		nClk = 16'd0;
		if (baseUnit != 8'hFF) nUnit = baseUnit + 8'd1;  // Saturate at 255
	end
end

// Trailing inactive run long enough ends reception
assign tmo = (state == irPkg::RX_RUN) && !curLvl && !lvlChg && (nUnit >= cfg_i.rxOffTmo);

always_comb begin
	memReq_o.we  = (state == irPkg::RX_STORE);
	memReq_o.re  = 1'b0;
	memReq_o.adr = 16'(adr);
	memReq_o.wd  = storeVal;
end

always_ff @(posedge CLK_i or posedge wRST) begin
	if (wRST) begin
		rxS1 <= 1'b0;
		rxS2 <= 1'b0;
	end else begin
		rxS1 <= rxd_i ^ cfg_i.rxPolInv;
		rxS2 <= rxS1;
	end
end

always_ff @(posedge CLK_i or posedge wRST) begin
	if (wRST) begin
		state          <= irPkg::RX_IDLE;
		curLvl         <= 1'b0;
		adr            <= '0;
		clkCnt         <= 16'd0;
		unitCnt        <= 8'd0;
		storeVal       <= 8'd0;
		busy_o         <= 1'b0;
		done_o         <= 1'b0;
		startClr_o     <= 1'b0;
		stopClr_o      <= 1'b0;
		rxCodeEndAdr_o <= 16'd0;
	end else begin
		startClr_o <= 1'b0;
		stopClr_o  <= 1'b0;
		done_o     <= 1'b0;
		if (stop_i && rxOn) begin
			stopClr_o <= 1'b1;
			if (state != irPkg::RX_IDLE) state <= irPkg::RX_DONE;
		end else begin
			case (state)
				irPkg::RX_IDLE: if (start_i && rxOn) begin
					startClr_o <= 1'b1;
					busy_o     <= 1'b1;
					adr        <= cfg_i.codeBgnAdr[MEM_ADR_WIDTH-1:0];
					curLvl     <= 1'b0;
					state      <= irPkg::RX_WAIT;
				end
				irPkg::RX_WAIT: if (rxS2) begin  // First active level opens a run
					curLvl  <= 1'b1;
					clkCnt  <= nClk;
					unitCnt <= nUnit;
					state   <= irPkg::RX_RUN;
				end
				irPkg::RX_RUN: begin
					clkCnt  <= nClk;
					unitCnt <= nUnit;
					if (lvlChg) begin
						curLvl   <= rxS2;
						storeVal <= unitCnt;
						state    <= irPkg::RX_STORE;
					end else if (tmo) begin
						state <= irPkg::RX_DONE;
					end
				end
				irPkg::RX_STORE: begin
					clkCnt  <= nClk;  // New run keeps counting
					unitCnt <= nUnit;
					adr     <= adrNext;
					if (adrNext == cfg_i.rxLimitAdr[MEM_ADR_WIDTH-1:0])
						state <= irPkg::RX_DONE;
					else
						state <= irPkg::RX_RUN;
				end
				irPkg::RX_DONE: begin
					rxCodeEndAdr_o <= 16'(adr);
					done_o         <= 1'b1;
					busy_o         <= 1'b0;
					state          <= irPkg::RX_IDLE;
				end
				default: state <= irPkg::RX_IDLE;
			endcase
		end
	end
end

endmodule

// ==== rtl/irTx.sv ====
// IR transmit engine, plays code bytes as carrier-modulated marks and flat spaces
`timescale 1ns/10ps
module irTx #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic               CLK_i,
	input  logic               wRST,
	input  irPkg::irCfg_t      cfg_i,
	input  logic               start_i,
	input  logic               stop_i,
	input  logic [7:0]         memRd_i,
	output irPkg::irMemReq_t   memReq_o,
	output logic               busy_o,
	output logic               done_o,
	output logic               startClr_o,
	output logic               stopClr_o,
	output logic               txd_o
);

irPkg::irTxState_e         state;
logic [MEM_ADR_WIDTH-1:0]  adr;       // Current entry
logic [7:0]                unitCnt;   // Carrier periods left in run
logic [7:0]                rptCnt;
logic [15:0]               clkCnt;    // Position inside carrier period
logic [1:0]                fetchCnt;
logic                      isMark, txOn, atEnd, perEnd;

assign txOn   = (cfg_i.mode == irPkg::IR_TX);
assign atEnd  = (adr == cfg_i.codeEndAdr[MEM_ADR_WIDTH-1:0]);
assign perEnd = ((clkCnt + 16'd1) >= cfg_i.crrCycLen);

always_comb begin
	memReq_o.we  = 1'b0;
	memReq_o.re  = (state == irPkg::TX_FETCH) && (fetchCnt == 2'd0) && !atEnd;
	memReq_o.adr = 16'(adr);
	memReq_o.wd  = 8'd0;
end

// High for the first txDutyLen clocks of each period
assign txd_o = (state == irPkg::TX_MARK) && (clkCnt < cfg_i.txDutyLen);

always_ff @(posedge CLK_i or posedge wRST) begin
	if (wRST) begin
		state      <= irPkg::TX_IDLE;
		adr        <= '0;
		unitCnt    <= 8'd0;
		rptCnt     <= 8'd0;
		clkCnt     <= 16'd0;
		fetchCnt   <= 2'd0;
		isMark     <= 1'b1;
		busy_o     <= 1'b0;
		done_o     <= 1'b0;
		startClr_o <= 1'b0;
		stopClr_o  <= 1'b0;
	end else begin
		startClr_o <= 1'b0;
		stopClr_o  <= 1'b0;
		done_o     <= 1'b0;
		if (stop_i && txOn) begin
			stopClr_o <= 1'b1;
			if (state != irPkg::TX_IDLE) state <= irPkg::TX_DONE;
		end else begin
			case (state)
				irPkg::TX_IDLE: if (start_i && txOn) begin
					startClr_o <= 1'b1;
					busy_o     <= 1'b1;
					adr        <= cfg_i.codeBgnAdr[MEM_ADR_WIDTH-1:0];
					rptCnt     <= cfg_i.txRptLen;
					isMark     <= 1'b1;
					fetchCnt   <= 2'd0;
					state      <= irPkg::TX_FETCH;
				end
				irPkg::TX_FETCH: begin
					if (fetchCnt == 2'd0) begin
						if (!atEnd) begin
							fetchCnt <= 2'd1;
						end else if (rptCnt == 8'd0) begin
							state <= irPkg::TX_DONE;
						end else begin  // Replay from the first entry
							rptCnt <= rptCnt - 8'd1;
							adr    <= cfg_i.codeBgnAdr[MEM_ADR_WIDTH-1:0];
							isMark <= 1'b1;
						end
					end else if (fetchCnt == 2'd1) begin
						fetchCnt <= 2'd2;
					end else begin
						fetchCnt <= 2'd0;
						clkCnt   <= 16'd0;
						unitCnt  <= memRd_i;
						if (memRd_i == 8'd0) begin  // Empty run, skip
							adr    <= adr + 1'b1;
							isMark <= ~isMark;
						end else begin
							state <= isMark ? irPkg::TX_MARK : irPkg::TX_SPACE;
						end
					end
				end
				irPkg::TX_MARK, irPkg::TX_SPACE: begin
					if (perEnd) begin
						clkCnt  <= 16'd0;
						unitCnt <= unitCnt - 8'd1;
						if (unitCnt == 8'd1) begin
							adr    <= adr + 1'b1;
							isMark <= ~isMark;
							state  <= irPkg::TX_FETCH;
						end
					end else begin
						clkCnt <= clkCnt + 16'd1;
					end
				end
				irPkg::TX_DONE: begin
					done_o <= 1'b1;
					busy_o <= 1'b0;
					state  <= irPkg::TX_IDLE;
				end
				default: state <= irPkg::TX_IDLE;
			endcase
		end
	end
end

endmodule

// ==== rtl/irTxRxTop.sv ====
// IR remote transmitter/receiver top, reset merge, memory arbitration and block wiring
`timescale 1ns/10ps
module irTxRxTop #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic        CLK_i,
	input  logic        RST_i,
	input  logic [7:0]  wbAdr_i,
	input  logic [7:0]  wbDat_i,
	input  logic        wbWe_i,
	input  logic        wbStb_i,
	input  logic        wbCyc_i,
	output logic [7:0]  wbDat_o,
	output logic        wbAck_o,
	input  logic        rxd_i,
	output logic        txd_o,
	output logic        rxGpio_o,
	output logic        intO_o
);

irPkg::irCfg_t     cfg;
irPkg::irMemReq_t  hostReq, txReq, rxReq, memReq;
logic              wRST, swRst, start, stop, busy, done, startClr, stopClr, intFlag;
logic              txBusy, rxBusy, txDone, rxDone;
logic              txStartClr, rxStartClr, txStopClr, rxStopClr;
logic [15:0]       rxCodeEndAdr;
logic [7:0]        memRd;

assign wRST     = RST_i | swRst;   // Hard or soft reset
assign busy     = txBusy | rxBusy;
assign done     = txDone | rxDone;
assign startClr = txStartClr | rxStartClr;
assign stopClr  = txStopClr | rxStopClr;
assign intO_o   = intFlag;

// Running engine owns the RAM, host otherwise
always_comb begin
	if (busy && (cfg.mode == irPkg::IR_TX))
		memReq = txReq;
	else if (busy && (cfg.mode == irPkg::IR_RX))
		memReq = rxReq;
	else
		memReq = hostReq;
end

irRegIf #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_regIf (
	.CLK_i(CLK_i), .RST_i(RST_i), .wRST(wRST),
	.wbAdr_i(wbAdr_i), .wbDat_i(wbDat_i), .wbWe_i(wbWe_i),
	.wbStb_i(wbStb_i), .wbCyc_i(wbCyc_i),
	.busy_i(busy), .done_i(done), .startClr_i(startClr), .stopClr_i(stopClr),
	.rxCodeEndAdr_i(rxCodeEndAdr), .memRd_i(memRd),
	.wbDat_o(wbDat_o), .wbAck_o(wbAck_o), .cfg_o(cfg),
	.start_o(start), .stop_o(stop), .swRst_o(swRst), .int_o(intFlag),
	.memReq_o(hostReq)
);

irTx #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_tx (
	.CLK_i(CLK_i), .wRST(wRST), .cfg_i(cfg), .start_i(start), .stop_i(stop),
	.memRd_i(memRd), .memReq_o(txReq), .busy_o(txBusy), .done_o(txDone),
	.startClr_o(txStartClr), .stopClr_o(txStopClr), .txd_o(txd_o)
);

irRx #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_rx (
	.CLK_i(CLK_i), .wRST(wRST), .cfg_i(cfg), .start_i(start), .stop_i(stop),
	.rxd_i(rxd_i), .memReq_o(rxReq), .busy_o(rxBusy), .done_o(rxDone),
	.startClr_o(rxStartClr), .stopClr_o(rxStopClr),
	.rxCodeEndAdr_o(rxCodeEndAdr), .rxGpio_o(rxGpio_o)
);

irCodeMem #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_mem (
	.CLK_i(CLK_i), .wRST(wRST), .memReq_i(memReq), .memRd_o(memRd)
);

endmodule

// ==== testbench/irTxRxTb.sv ====
// IR transmitter/receiver testbench, register, memory window, TX, RX, GPIO, interrupt and stop
`timescale 1ns/10ps
module irTxRxTb;

localparam int MEM_ADR_WIDTH = 11;
localparam int NUM_CASES     = 4;
localparam int BUS_TMO       = 20;      // Cycles to wait for ack
localparam int RUN_TMO       = 200000;  // Cycles to wait for an engine
localparam int POLL_TMO      = 20000;   // STATUS polls before giving up
localparam int STOP_POLLS    = 8;       // Stop must end the run within a few polls

typedef struct packed {
	irPkg::irMode_e    mode;
	logic [15:0]       crr;
	logic [15:0]       duty;
	logic [7:0]        rpt;
	logic              pol;
	logic              intEn;
	logic [15:0]       bgn;
	logic [7:0]        limOff;   // RX limit relative to begin
	logic [3:0]        n;        // Code bytes or RXD runs
	logic [4:0][15:0]  runs;     // RX run lengths in units
} tbCase_t;

logic        clk, rst, wbWe, wbStb, wbCyc, wbAck, rxd, txd, rxGpio, intO;
logic [7:0]  wbAdr, wbDatIn, wbDatOut;
tbCase_t     cases [NUM_CASES];

irTxRxTop #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_dut (
	.CLK_i(clk), .RST_i(rst), .wbAdr_i(wbAdr), .wbDat_i(wbDatIn), .wbWe_i(wbWe),
	.wbStb_i(wbStb), .wbCyc_i(wbCyc), .wbDat_o(wbDatOut), .wbAck_o(wbAck),
	.rxd_i(rxd), .txd_o(txd), .rxGpio_o(rxGpio), .intO_o(intO)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

// ********************
// Checks
// ********************
task automatic failStop();
	$display("Test failures found");
	$fatal(1, "Simulation stopped at first error");
endtask

task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("[FAIL] %s expected 0x%02h actual 0x%02h", name, exp, act);
		failStop();
	end
endtask

task automatic checkLevel(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("[FAIL] %s expected %b actual %b", name, exp, act);
		failStop();
	end
endtask

task automatic checkAdr(input string name, input logic [15:0] exp, input logic [15:0] act);
	if (act !== exp) begin
		$display("[FAIL] %s expected 0x%04h actual 0x%04h", name, exp, act);
		failStop();
	end
endtask

// ********************
// Bus access
// ********************
task automatic busWrite(input logic [7:0] adr, input logic [7:0] dat);
	int cnt;
	cnt = 0;
	@(posedge clk);
	wbAdr   <= adr;
	wbDatIn <= dat;
	wbWe    <= 1'b1;
	wbStb   <= 1'b1;
	wbCyc   <= 1'b1;
	@(negedge clk);
	while (wbAck !== 1'b1 && cnt < BUS_TMO) begin
		cnt++;
		@(negedge clk);
	end
	if (wbAck !== 1'b1) begin
		$display("Bus write to register 0x%02h was never acknowledged", adr);
		failStop();
	end
	@(posedge clk);
	wbStb <= 1'b0;
	wbCyc <= 1'b0;
	wbWe  <= 1'b0;
endtask

task automatic busRead(input logic [7:0] adr, output logic [7:0] dat);
	int cnt;
	cnt = 0;
	@(posedge clk);
	wbAdr <= adr;
	wbWe  <= 1'b0;
	wbStb <= 1'b1;
	wbCyc <= 1'b1;
	@(negedge clk);
	while (wbAck !== 1'b1 && cnt < BUS_TMO) begin
		cnt++;
		@(negedge clk);
	end
	if (wbAck !== 1'b1) begin
		$display("Bus read of register 0x%02h was never acknowledged", adr);
		failStop();
	end
	dat = wbDatOut;
	@(posedge clk);
	wbStb <= 1'b0;
	wbCyc <= 1'b0;
endtask

task automatic waitIdle(input string name, input int maxPolls);
	logic [7:0] st;
	int         cnt;
	cnt = 0;
	busRead(irPkg::STATUS, st);
	while (st[irPkg::STAT_BUSY] && cnt < maxPolls) begin
		cnt++;
		busRead(irPkg::STATUS, st);
	end
	if (st[irPkg::STAT_BUSY]) begin
		$display("Engine stayed busy too long in %s", name);
		failStop();
	end
endtask

task automatic setPtr(input logic [15:0] adr);
	busWrite(irPkg::MADR_LO, adr[7:0]);
	busWrite(irPkg::MADR_HI, adr[15:8]);
endtask

function automatic tbCase_t mkCase(input irPkg::irMode_e mode, input int crr, input int duty,
		input int rpt, input logic pol, input logic intEn, input int bgn, input int limOff,
		input int n, input int r0, input int r1, input int r2, input int r3, input int r4);
	tbCase_t c;
	c.mode    = mode;
	c.crr     = 16'(crr);
	c.duty    = 16'(duty);
	c.rpt     = 8'(rpt);
	c.pol     = pol;
	c.intEn   = intEn;
	c.bgn     = 16'(bgn);
	c.limOff  = 8'(limOff);
	c.n       = 4'(n);
	c.runs[0] = 16'(r0);
	c.runs[1] = 16'(r1);
	c.runs[2] = 16'(r2);
	c.runs[3] = 16'(r3);
	c.runs[4] = 16'(r4);
	return c;
endfunction

// ********************
// Register and memory tests
// ********************
task automatic testRegs();
	logic [7:0] regs[$];
	logic [7:0] vals[$];
	logic [7:0] d;
	regs = '{8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h09,
		8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h10, 8'h11};
	for (int a = 0; a <= 8'h11; a++) begin
		busRead(8'(a), d);
		checkByte($sformatf("reset value reg 0x%02h", a), 8'h00, d);
	end
	foreach (regs[i]) begin
		vals.push_back(8'($urandom));
		busWrite(regs[i], vals[i]);
	end
	foreach (regs[i]) begin
		busRead(regs[i], d);
		checkByte($sformatf("readback reg 0x%02h", regs[i]), vals[i], d);
	end
	busWrite(irPkg::CTRL, 8'h40);  // Soft reset
	repeat (3) @(posedge clk);
	foreach (regs[i]) begin
		busRead(regs[i], d);
		checkByte($sformatf("soft reset reg 0x%02h", regs[i]), 8'h00, d);
	end
endtask

task automatic testMemWin();
	logic [7:0] data[$];
	logic [7:0] d;
	setPtr(16'h03F0);  // Crosses into the upper bank
	for (int i = 0; i < 32; i++) begin
		data.push_back(8'($urandom));
		busWrite(irPkg::MDATA, data[i]);
	end
	busRead(irPkg::MADR_HI, d);
	checkByte("pointer after writes", 8'h04, d);
	setPtr(16'h03F0);
	foreach (data[i]) begin
		busRead(irPkg::MDATA, d);
		checkByte($sformatf("memory window byte %0d", i), data[i], d);
	end
endtask

// ********************
// Engine tests
// ********************
task automatic runTx(input tbCase_t c, input int idx);
	logic [7:0] codes[$];
	int         expMarks[$];
	int         cnt, hi, lo, pulses, gIdx;
	logic       fin;
	string      tag;
	tag = $sformatf("TX case %0d", idx);
	busWrite(irPkg::CRR_LO, c.crr[7:0]);
	busWrite(irPkg::CRR_HI, c.crr[15:8]);
	busWrite(irPkg::DUTY_LO, c.duty[7:0]);
	busWrite(irPkg::DUTY_HI, c.duty[15:8]);
	busWrite(irPkg::RPT, c.rpt);
	busWrite(irPkg::BGN_LO, c.bgn[7:0]);
	busWrite(irPkg::BGN_HI, c.bgn[15:8]);
	busWrite(irPkg::END_LO, 8'(c.bgn + 16'(c.n)));
	busWrite(irPkg::END_HI, 8'((c.bgn + 16'(c.n)) >> 8));
	setPtr(c.bgn);
	for (int i = 0; i < c.n; i++) begin
		codes.push_back(8'(1 + $urandom % 3));
		busWrite(irPkg::MDATA, codes[i]);
	end
	for (int r = 0; r <= c.rpt; r++)
		for (int i = 0; i < c.n; i += 2) expMarks.push_back(codes[i]);  // Marks only
	busWrite(irPkg::CTRL, 8'h01 | {5'd0, c.intEn, 2'b00});
	cnt = 0;
	hi = 0;
	lo = 0;
	pulses = 0;
	gIdx = 0;
	fin = 1'b0;
	while (!fin && cnt < RUN_TMO) begin
		@(negedge clk);
		cnt++;
		if (txd) begin
			// Long low gap means a new mark began
			if (hi == 0 && pulses > 0 && lo > int'(c.crr - c.duty)) begin
				if (gIdx >= expMarks.size()) begin
					$display("%s produced more marks than expected", tag);
					failStop();
				end
				checkByte({tag, " pulses per mark"}, 8'(expMarks[gIdx]), 8'(pulses));
				gIdx++;
				pulses = 0;
			end
			hi++;
			lo = 0;
		end else begin
			if (hi > 0) begin
				checkAdr({tag, " pulse width"}, c.duty, 16'(hi));
				pulses++;
				hi = 0;
			end
			lo++;
		end
		fin = u_dut.done;
	end
	if (!fin) begin
		$display("%s never finished", tag);
		failStop();
	end
	checkByte({tag, " pulses in last mark"}, 8'(expMarks[gIdx]), 8'(pulses));
	checkByte({tag, " mark count"}, 8'(expMarks.size()), 8'(gIdx + 1));
	for (int i = 0; i < 4; i++) begin
		@(negedge clk);
		checkLevel({tag, " TXD after done"}, 1'b0, txd);
	end
	checkLevel({tag, " interrupt"}, c.intEn, intO);
	waitIdle(tag, POLL_TMO);
	if (c.intEn) begin
		busWrite(irPkg::STATUS, 8'h02);
		@(negedge clk);
		checkLevel({tag, " interrupt clear"}, 1'b0, intO);
	end
endtask

task automatic runRx(input tbCase_t c, input int idx);
	logic [7:0]  d, lo8;
	logic [15:0] rend, run;
	int          nStore;
	string       tag;
	tag = $sformatf("RX case %0d", idx);
	nStore = (c.n < c.limOff) ? c.n : c.limOff;
	busWrite(irPkg::CRR_LO, c.crr[7:0]);
	busWrite(irPkg::CRR_HI, c.crr[15:8]);
	busWrite(irPkg::OFF_TMO, 8'd20);
	busWrite(irPkg::BGN_LO, c.bgn[7:0]);
	busWrite(irPkg::BGN_HI, c.bgn[15:8]);
	busWrite(irPkg::LIM_LO, 8'(c.bgn + 16'(c.limOff)));
	busWrite(irPkg::LIM_HI, 8'((c.bgn + 16'(c.limOff)) >> 8));
	@(posedge clk);
	rxd <= c.pol;  // Inactive level
	// Polarity settles through the synchronizer before start
	busWrite(irPkg::CTRL, 8'h02 | {4'd0, c.pol, c.intEn, 2'b00});
	busWrite(irPkg::CTRL, 8'h03 | {4'd0, c.pol, c.intEn, 2'b00});
	repeat (4) @(posedge clk);
	for (int i = 0; i < c.n; i++) begin
		@(posedge clk);
		rxd <= ((i % 2) == 0) ^ c.pol;
		repeat (int'(c.runs[i]) * int'(c.crr) - 1) @(posedge clk);
	end
	@(posedge clk);
	rxd <= c.pol;  // Silence ends reception
	waitIdle(tag, POLL_TMO);
	checkLevel({tag, " interrupt"}, c.intEn, intO);
	busRead(irPkg::REND_LO, lo8);
	busRead(irPkg::REND_HI, d);
	rend = {d, lo8};
	checkAdr({tag, " end address"}, c.bgn + 16'(nStore), rend);
	setPtr(c.bgn);
	for (int i = 0; i < nStore; i++) begin
		run = c.runs[i];
		busRead(irPkg::MDATA, d);
		checkByte($sformatf("%s run %0d", tag, i), (run > 16'd255) ? 8'd255 : run[7:0], d);
	end
	if (c.intEn) busWrite(irPkg::STATUS, 8'h02);
endtask

task automatic testGpio();
	busWrite(irPkg::CTRL, 8'h12);  // GPIO enabled, RX mode
	@(posedge clk);
	rxd <= 1'b1;
	repeat (3) @(posedge clk);
	@(negedge clk);
	checkLevel("GPIO follows high", 1'b1, rxGpio);
	@(posedge clk);
	rxd <= 1'b0;
	repeat (3) @(posedge clk);
	@(negedge clk);
	checkLevel("GPIO follows low", 1'b0, rxGpio);
	busWrite(irPkg::CTRL, 8'h1A);
	repeat (3) @(posedge clk);
	@(negedge clk);
	checkLevel("GPIO inverted", 1'b1, rxGpio);
	busWrite(irPkg::CTRL, 8'h0A);
	repeat (3) @(posedge clk);
	@(negedge clk);
	checkLevel("GPIO disabled", 1'b0, rxGpio);
	busWrite(irPkg::CTRL, 8'h00);
endtask

task automatic testStop();
	logic [7:0] st;
	busWrite(irPkg::CRR_LO, 8'd10);
	busWrite(irPkg::CRR_HI, 8'd0);
	busWrite(irPkg::DUTY_LO, 8'd5);
	busWrite(irPkg::RPT, 8'd0);
	busWrite(irPkg::BGN_LO, 8'h20);
	busWrite(irPkg::BGN_HI, 8'h00);
	busWrite(irPkg::END_LO, 8'h22);
	busWrite(irPkg::END_HI, 8'h00);
	setPtr(16'h0020);
	busWrite(irPkg::MDATA, 8'hFF);
	busWrite(irPkg::MDATA, 8'hFF);
	busWrite(irPkg::CTRL, 8'h01);
	repeat (50) @(posedge clk);
	busRead(irPkg::STATUS, st);
	checkLevel("busy before stop", 1'b1, st[irPkg::STAT_BUSY]);
	busWrite(irPkg::CTRL, 8'h20);
	waitIdle("stop test", STOP_POLLS);  // Far shorter than the remaining mark
	for (int i = 0; i < 20; i++) begin
		@(negedge clk);
		checkLevel("TXD after stop", 1'b0, txd);
	end
endtask

// ********************
// Main sequence
// ********************
initial begin
	rst     = 1'b1;
	wbAdr   = 8'd0;
	wbDatIn = 8'd0;
	wbWe    = 1'b0;
	wbStb   = 1'b0;
	wbCyc   = 1'b0;
	rxd     = 1'b0;
	void'($urandom(32'heb52));
	cases[0] = mkCase(irPkg::IR_TX, 5, 2, 1, 1'b0, 1'b1, 16'h010, 0, 4, 0, 0, 0, 0, 0);
	cases[1] = mkCase(irPkg::IR_TX, 8, 3, 0, 1'b0, 1'b0, 16'h405, 0, 5, 0, 0, 0, 0, 0);
	cases[2] = mkCase(irPkg::IR_RX, 4, 0, 0, 1'b0, 1'b1, 16'h100, 50, 5, 3, 2, 300, 5, 1);
	cases[3] = mkCase(irPkg::IR_RX, 6, 0, 0, 1'b1, 1'b0, 16'h600, 2, 5, 2, 3, 4, 1, 2);
	repeat (10) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	checkLevel("TXD after reset", 1'b0, txd);
	checkLevel("GPIO after reset", 1'b0, rxGpio);
	checkLevel("interrupt after reset", 1'b0, intO);
	checkLevel("ack after reset", 1'b0, wbAck);
	testRegs();
	testMemWin();
	for (int i = 0; i < NUM_CASES; i++) begin
		if (cases[i].mode == irPkg::IR_TX)
			runTx(cases[i], i);
		else
			runRx(cases[i], i);
	end
	testGpio();
	testStop();
	$display("All tests passed!");
	$finish;
end

endmodule

// ==== verilog.f ====
rtl/irPkg.sv
rtl/irCodeMem.sv
rtl/irRegIf.sv
rtl/irTx.sv
rtl/irRx.sv
rtl/irTxRxTop.sv
testbench/irTxRxTb.sv
